// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_nes_loader
FILELIST  ?= nes_loader.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert -Wno-fatal

SRCS := $(shell grep -v '^+' $(FILELIST)) tb_nes_loader_tasks.svh
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; \
	echo "$$out" | grep -qx "Simulation PASSED"

clean:
	rm -rf $(OBJ_DIR)

// ==== host_reg_decode.sv ====
`timescale 1ns/1ps
// Host register decoder
module host_reg_decode (
  input  logic                     clk,
  input  logic                     clk_spi,
  input  nes_loader_pkg::host_wr_t host,
  output logic [7:0]               load_byte,
  output logic                     load_stb,
  output logic                     loader_reset,
  output logic [7:0]               pad1_bits,
  output logic [7:0]               pad2_bits
);
  import nes_loader_pkg::*;

  logic conf_hold;  // Bit 0 of the config byte

  always_ff @(posedge clk or posedge clk_spi) begin
    if (clk_spi) begin
      conf_hold <= 1'b0;
      pad1_bits <= '0;
      pad2_bits <= '0;
    end else if (host.write) begin
      case (host.addr)
        HOST_ADDR_CONF: conf_hold <= host.data[0];
        HOST_ADDR_PAD1: pad1_bits <= host.data;
        HOST_ADDR_PAD2: pad2_bits <= host.data;
        default: ;  // Other addresses ignored
      endcase
    end
  end

  // Image bytes go straight through in the write cycle
  assign load_byte = host.data;
  assign load_stb  = host.write && (host.addr == HOST_ADDR_LOAD);

  // Loader held while system reset or config hold is set
  assign loader_reset = clk_spi | conf_hold;

endmodule

// ==== ines_loader.sv ====
`timescale 1ns/1ps
// iNES image loader
module ines_loader (
  input  logic                          clk,
  input  logic                          clk_spi,
  input  logic [7:0]                    load_byte,
  input  logic                          load_stb,
  output nes_loader_pkg::mem_wr_t       mem_wr,
  output nes_loader_pkg::mapper_flags_t mapper_flags,
  output logic                          done,
  output logic                          error
);
  import nes_loader_pkg::*;

  localparam int unsigned CTR_W = $clog2(INES_HDR_LEN);

  typedef enum logic [1:0] {
    ST_HDR  = 2'd0,
    ST_PRG  = 2'd1,
    ST_CHR  = 2'd2,
    ST_FAIL = 2'd3
  } load_state_e;

  load_state_e            state;
  logic [CTR_W-1:0]       hdr_ctr;
  logic [7:0]             ines [INES_HDR_LEN];
  logic [LOAD_ADDR_W-1:0] load_addr;
  logic [LOAD_ADDR_W-1:0] bytes_left;
  logic [LOAD_ADDR_W-1:0] prg_bytes;
  logic [LOAD_ADDR_W-1:0] chr_bytes;
  logic                   hdr_ok;
  logic                   accept;

  // Bank count to log2 size, 0 for 0 or 1 bank, saturating at 7
  function automatic logic [2:0] size_code(input logic [7:0] banks);
    logic [2:0] code;
    code = 3'd7;
    for (int i = 6; i >= 0; i--) begin
      if (banks <= (8'd1 << i)) code = 3'(i);
    end
    return code;
  endfunction

  assign prg_bytes = LOAD_ADDR_W'(ines[4]) << PRG_BANK_SHIFT;
  assign chr_bytes = LOAD_ADDR_W'(ines[5]) << CHR_BANK_SHIFT;

  // Magic must match, no trainer and no four-screen layout
  assign hdr_ok = ({ines[0], ines[1], ines[2], ines[3]} == INES_MAGIC) &&
                  !ines[6][2] && !ines[6][3];

  assign accept = load_stb && (bytes_left != '0) &&
                  ((state == ST_PRG) || (state == ST_CHR));

  // Header capture
  always_ff @(posedge clk) begin
    if ((state == ST_HDR) && load_stb) ines[hdr_ctr] <= load_byte;
  end

  // ========================================
  // Load sequencer
  // ========================================
  always_ff @(posedge clk or posedge clk_spi) begin
    if (clk_spi) begin
      state      <= ST_HDR;
      hdr_ctr    <= '0;
      load_addr  <= '0;  // PRG starts at 0
      bytes_left <= '0;
      done       <= 1'b0;
    end else begin
      case (state)
        ST_HDR: begin
          if (load_stb) begin
            hdr_ctr <= hdr_ctr + 1'b1;
            if (hdr_ctr == CTR_W'(INES_HDR_LEN - 1)) begin
              if (hdr_ok) begin
                state      <= ST_PRG;
                bytes_left <= prg_bytes;
              end else begin
                state <= ST_FAIL;
              end
            end
          end
        end
        ST_PRG: begin
          // Switch to CHR on the last PRG byte so no stream byte is lost
          if ((bytes_left == '0) || (accept && (bytes_left == LOAD_ADDR_W'(1)))) begin
            state      <= ST_CHR;
            load_addr  <= CHR_BASE_ADDR;
            bytes_left <= chr_bytes;
          end else if (accept) begin
            bytes_left <= bytes_left - 1'b1;
            load_addr  <= load_addr + 1'b1;
          end
        end
        ST_CHR: begin
          if (bytes_left == '0) begin
            done <= 1'b1;  // Image complete, later strobes ignored
          end else if (accept) begin
            bytes_left <= bytes_left - 1'b1;
            load_addr  <= load_addr + 1'b1;
          end
        end
        default: ;  // Stuck in fail until reset
      endcase
    end
  end

  assign error = (state == ST_FAIL);

  always_comb begin
    mem_wr.addr  = load_addr;
    mem_wr.data  = load_byte;
    mem_wr.write = accept;
  end

  // Flags packed for the console core
  always_comb begin
    mapper_flags.reserved    = '0;
    mapper_flags.hdr7_lo     = ines[7][3:0];
    mapper_flags.hdr6_lo     = ines[6][3:0];
    mapper_flags.has_chr_ram = (ines[5] == 8'd0);
    mapper_flags.mirroring   = ines[6][0];
    mapper_flags.chr_size    = size_code(ines[5]);
    mapper_flags.prg_size    = size_code(ines[4]);
    mapper_flags.mapper      = {ines[7][7:4], ines[6][7:4]};
  end

endmodule

// ==== joypad_serializer.sv ====
`timescale 1ns/1ps
// Two-player joypad serializer
module joypad_serializer (
  input  logic       clk,
  input  logic       clk_spi,
  input  logic [7:0] pad1_bits,
  input  logic [7:0] pad2_bits,
  input  logic       strobe,
  input  logic [1:0] pad_clock,
  output logic [1:0] data
);

  logic [1:0][7:0] shift_q;      // Index 0 is player 1
  logic [1:0]      pad_clock_q;
  logic [1:0]      pad_fall;

  // Falling edge seen against last cycle's clock level
  assign pad_fall = pad_clock_q & ~pad_clock;

  always_ff @(posedge clk or posedge clk_spi) begin
    if (clk_spi) begin
      shift_q     <= '0;
      pad_clock_q <= '0;
    end else begin
      pad_clock_q <= pad_clock;
      if (strobe) begin
        shift_q[0] <= pad1_bits;
        shift_q[1] <= pad2_bits;
      end
      // A shift in the same cycle wins over the reload
      for (int i = 0; i < 2; i++) begin
        if (pad_fall[i]) shift_q[i] <= {1'b0, shift_q[i][7:1]};
      end
    end
  end

  // Current button bit per player
  assign data = {shift_q[1][0], shift_q[0][0]};

endmodule

// ==== nes_loader.f ====
+incdir+.
nes_loader_pkg.sv
host_reg_decode.sv
ines_loader.sv
joypad_serializer.sv
nes_loader_top.sv
tb_nes_loader.sv

// ==== nes_loader_pkg.sv ====
// NES loader shared definitions
package nes_loader_pkg;

  // ========================================
  // Host register map
  // ========================================
  localparam logic [7:0] HOST_ADDR_CONF = 8'h35;  // Config byte, bit 0 holds loader in reset
  localparam logic [7:0] HOST_ADDR_LOAD = 8'h37;  // Cartridge image stream
  localparam logic [7:0] HOST_ADDR_PAD1 = 8'h40;  // Player 1 buttons
  localparam logic [7:0] HOST_ADDR_PAD2 = 8'h41;  // Player 2 buttons

  // ========================================
  // Loader constants
  // ========================================
  localparam int unsigned LOAD_ADDR_W = 22;

  // CHR data lives in the upper half of the load space
  localparam logic [LOAD_ADDR_W-1:0] CHR_BASE_ADDR = 22'h200000;

  localparam int unsigned PRG_BANK_SHIFT = 14;  // 16 KiB
  localparam int unsigned CHR_BANK_SHIFT = 13;  // 8 KiB
  localparam int unsigned INES_HDR_LEN   = 16;

  localparam logic [31:0] INES_MAGIC = 32'h4E45_531A;  // "NES",0x1A

  // ========================================
  // Bundled signals
  // ========================================
  typedef struct packed {
    logic [7:0] addr;
    logic [7:0] data;
    logic       write;
  } host_wr_t;

  typedef struct packed {
    logic [LOAD_ADDR_W-1:0] addr;
    logic [7:0]             data;
    logic                   write;
  } mem_wr_t;

  // Cartridge flags as the console core expects them
  typedef struct packed {
    logic [7:0] reserved;     // Always zero
    logic [3:0] hdr7_lo;
    logic [3:0] hdr6_lo;
    logic       has_chr_ram;
    logic       mirroring;
    logic [2:0] chr_size;     // Log2 of CHR bank count
    logic [2:0] prg_size;     // Log2 of PRG bank count
    logic [7:0] mapper;
  } mapper_flags_t;

endpackage

// ==== nes_loader_top.sv ====
`timescale 1ns/1ps
// NES ROM loader and joypad top level
module nes_loader_top (
  input  logic                          clk,
  input  logic                          clk_spi,
  input  nes_loader_pkg::host_wr_t      host,
  input  logic                          joypad_strobe,
  input  logic [1:0]                    joypad_clock,
  output nes_loader_pkg::mem_wr_t       mem_wr,
  output nes_loader_pkg::mapper_flags_t mapper_flags,
  output logic                          load_done,
  output logic                          load_error,
  output logic [1:0]                    joypad_data
);

  logic [7:0] load_byte;
  logic       load_stb;
  logic       loader_reset;
  logic [7:0] pad1_bits;
  logic [7:0] pad2_bits;

  host_reg_decode u_decode (
    .clk          (clk),
    .clk_spi      (clk_spi),
    .host         (host),
    .load_byte    (load_byte),
    .load_stb     (load_stb),
    .loader_reset (loader_reset),
    .pad1_bits    (pad1_bits),
    .pad2_bits    (pad2_bits)
  );

  // Loader sees the combined system and config reset
  ines_loader u_loader (
    .clk          (clk),
    .clk_spi      (loader_reset),
    .load_byte    (load_byte),
    .load_stb     (load_stb),
    .mem_wr       (mem_wr),
    .mapper_flags (mapper_flags),
    .done         (load_done),
    .error        (load_error)
  );

  joypad_serializer u_joypad (
    .clk       (clk),
    .clk_spi   (clk_spi),
    .pad1_bits (pad1_bits),
    .pad2_bits (pad2_bits),
    .strobe    (joypad_strobe),
    .pad_clock (joypad_clock),
    .data      (joypad_data)
  );

endmodule

// ==== tb_nes_loader_tasks.svh ====
// Testbench drive tasks

// One host register write, held for a single clock
task automatic host_write(input logic [7:0] addr, input logic [7:0] data);
  host.addr  = addr;
  host.data  = data;
  host.write = 1'b1;
  @(negedge clk);
  host.write = 1'b0;
endtask

// Config bit 0 pulsed high then low
task automatic reset_loader();
  host_write(HOST_ADDR_CONF, 8'h01);
  host_write(HOST_ADDR_CONF, 8'h00);
endtask

// iNES header, last magic byte wrong when bad_magic is set
task automatic send_header(input int prg, input int chr, input logic [7:0] b6,
                           input logic [7:0] b7, input bit bad_magic);
  logic [7:0] hdr [16];
  for (int i = 0; i < 16; i++) hdr[i] = 8'h00;
  hdr[0] = 8'h4E;
  hdr[1] = 8'h45;
  hdr[2] = 8'h53;
  hdr[3] = bad_magic ? 8'h1B : 8'h1A;
  hdr[4] = 8'(prg);
  hdr[5] = 8'(chr);
  hdr[6] = b6;
  hdr[7] = b7;
  for (int i = 0; i < 16; i++) host_write(HOST_ADDR_LOAD, hdr[i]);
endtask

// PRG banks of 16 KiB from 0, then CHR banks of 8 KiB from the CHR base
task automatic send_body(input int prg, input int chr);
  logic [7:0] d;
  for (int i = 0; i < prg * 16384; i++) begin
    d = 8'($random(seed));
    exp_addr_q.push_back(22'(i));
    exp_data_q.push_back(d);
    host_write(HOST_ADDR_LOAD, d);
  end
  for (int j = 0; j < chr * 8192; j++) begin
    d = 8'($random(seed));
    exp_addr_q.push_back(CHR_BASE_ADDR + 22'(j));
    exp_data_q.push_back(d);
    host_write(HOST_ADDR_LOAD, d);
  end
endtask

// Stream bytes that must not reach memory
task automatic send_junk(input int count);
  for (int i = 0; i < count; i++) host_write(HOST_ADDR_LOAD, 8'($random(seed)));
endtask

task automatic strobe_pads();
  joypad_strobe = 1'b1;
  @(negedge clk);
  joypad_strobe = 1'b0;
endtask

// High for one cycle, then the falling edge
task automatic pulse_pad_clock(input int player);
  joypad_clock[player] = 1'b1;
  @(negedge clk);
  joypad_clock[player] = 1'b0;
  @(negedge clk);
endtask

// ==== tb_nes_loader.sv ====
`timescale 1ns/1ps
// NES loader testbench
module tb_nes_loader;
  import nes_loader_pkg::*;

  logic          clk;
  logic          clk_spi;
  host_wr_t      host;
  logic          joypad_strobe;
  logic [1:0]    joypad_clock;
  mem_wr_t       mem_wr;
  mapper_flags_t mapper_flags;
  logic          load_done;
  logic          load_error;
  logic [1:0]    joypad_data;

  integer        seed;
  int            errors;
  int            checks;
  string         test_name;
  logic [21:0]   exp_addr_q [$];  // Scoreboard of expected memory writes
  logic [7:0]    exp_data_q [$];
  logic [21:0]   exp_addr;
  logic [7:0]    exp_data;
  logic [7:0]    pad1;
  logic [7:0]    pad2;
  logic [7:0]    shifted;
  mapper_flags_t flags_before;
  logic [7:0]    other_addrs [7];

  `include "tb_nes_loader_tasks.svh"

  nes_loader_top UUT (
    .clk           (clk),
    .clk_spi       (clk_spi),
    .host          (host),
    .joypad_strobe (joypad_strobe),
    .joypad_clock  (joypad_clock),
    .mem_wr        (mem_wr),
    .mapper_flags  (mapper_flags),
    .load_done     (load_done),
    .load_error    (load_error),
    .joypad_data   (joypad_data)
  );

  always #5 clk = ~clk;

  task automatic check_eq(input string label, input logic [31:0] expected,
                          input logic [31:0] actual);
    checks++;
    assert (expected === actual) else begin
      errors++;
      $display("[ERROR] %s %s: expected %0h, actual %0h", test_name, label, expected, actual);
    end
  endtask

  task automatic wait_level(input bit pick_error, input int limit, input string what);
    bit seen;
    seen = 1'b0;
    for (int c = 0; c <= limit && !seen; c++) begin
      seen = pick_error ? load_error : load_done;
      if (!seen) @(negedge clk);
    end
    if (!seen) begin
      errors++;
      $display("Timeout: %s did not rise within %0d cycles in test %s", what, limit, test_name);
    end
  endtask

  // Log2 of the bank count rounded up and capped at 7
  function automatic logic [2:0] log2_size(input int banks);
    int c;
    c = 0;
    while (c < 7 && (1 << c) < banks) c++;
    return 3'(c);
  endfunction

  function automatic mapper_flags_t expected_flags(input int prg, input int chr,
                                                   input logic [7:0] b6, input logic [7:0] b7);
    mapper_flags_t f;
    f             = '0;
    f.hdr7_lo     = b7[3:0];
    f.hdr6_lo     = b6[3:0];
    f.has_chr_ram = (chr == 0);
    f.mirroring   = b6[0];
    f.chr_size    = log2_size(chr);
    f.prg_size    = log2_size(prg);
    f.mapper      = {b7[7:4], b6[7:4]};
    return f;
  endfunction

  // ========================================
  // Assertions and memory scoreboard
  // ========================================
  a_no_write_on_error: assert property (@(posedge clk) disable iff (clk_spi)
    load_error |-> !mem_wr.write) else begin
    errors++;
    $display("Memory write seen while load_error is high in test %s", test_name);
  end

  a_write_needs_strobe: assert property (@(posedge clk) disable iff (clk_spi)
    mem_wr.write |-> (host.write && host.addr == HOST_ADDR_LOAD)) else begin
    errors++;
    $display("Memory write without an image byte strobe in test %s", test_name);
  end

  always @(posedge clk) begin
    if (!clk_spi && mem_wr.write) begin
      if (exp_addr_q.size() == 0) begin
        errors++;
        $display("Unexpected memory write to %h in test %s", mem_wr.addr, test_name);
      end else begin
        exp_addr = exp_addr_q.pop_front();
        exp_data = exp_data_q.pop_front();
        check_eq("mem addr", 32'(exp_addr), 32'(mem_wr.addr));
        check_eq("mem data", 32'(exp_data), 32'(mem_wr.data));
      end
    end
  end

  // ========================================
  // Test sequence
  // ========================================
  initial begin
    clk           = 1'b0;
    clk_spi       = 1'b1;
    host          = '0;
    joypad_strobe = 1'b0;
    joypad_clock  = 2'b00;
    seed          = 74;
    errors        = 0;
    checks        = 0;
    test_name     = "reset";
    other_addrs   = '{8'h00, 8'h34, 8'h36, 8'h38, 8'h3F, 8'h42, 8'hFF};
    repeat (5) @(negedge clk);
    clk_spi = 1'b0;
    @(negedge clk);

    test_name = "joypad";
    pad1 = 8'($random(seed));
    pad2 = 8'($random(seed));
    host_write(HOST_ADDR_PAD1, pad1);
    host_write(HOST_ADDR_PAD2, pad2);
    strobe_pads();
    check_eq("data after strobe", 32'({pad2[0], pad1[0]}), 32'(joypad_data));
    for (int k = 1; k <= 9; k++) begin
      pulse_pad_clock(0);
      shifted = pad1 >> k;  // Zero once k reaches 8
      check_eq("player 1 shift", 32'({pad2[0], shifted[0]}), 32'(joypad_data));
    end
    for (int k = 1; k <= 9; k++) begin
      pulse_pad_clock(1);
      shifted = pad2 >> k;
      check_eq("player 2 shift", 32'({shifted[0], 1'b0}), 32'(joypad_data));
    end

    test_name = "prg1_chr0";
    send_header(1, 0, 8'h01, 8'h00, 1'b0);
    send_body(1, 0);
    wait_level(1'b0, 2, "load_done");
    check_eq("mapper flags", expected_flags(1, 0, 8'h01, 8'h00), mapper_flags);

    test_name = "conf_reset";
    host_write(HOST_ADDR_CONF, 8'h01);
    check_eq("done in conf reset", 32'd0, 32'(load_done));
    check_eq("error in conf reset", 32'd0, 32'(load_error));
    host_write(HOST_ADDR_CONF, 8'h00);

    test_name = "prg2_chr1";
    send_header(2, 1, 8'hA1, 8'h48, 1'b0);
    // Loader now takes PRG bytes, so a stray decode would show up as a write
    for (int i = 0; i < 7; i++) host_write(other_addrs[i], 8'($random(seed)));
    send_body(2, 1);
    wait_level(1'b0, 2, "load_done");
    check_eq("mapper flags", expected_flags(2, 1, 8'hA1, 8'h48), mapper_flags);
    check_eq("mapper number", 32'h4A, 32'(mapper_flags.mapper));

    test_name    = "other_addr";
    flags_before = mapper_flags;
    for (int i = 0; i < 7; i++) host_write(other_addrs[i], 8'($random(seed)));
    strobe_pads();
    check_eq("pad data", 32'({pad2[0], pad1[0]}), 32'(joypad_data));
    check_eq("load done", 32'd1, 32'(load_done));
    check_eq("load error", 32'd0, 32'(load_error));
    check_eq("mapper flags", flags_before, mapper_flags);

    test_name = "bad_magic";
    reset_loader();
    send_header(1, 0, 8'h00, 8'h00, 1'b1);
    wait_level(1'b1, 0, "load_error");
    send_junk(32);
    host_write(HOST_ADDR_CONF, 8'h01);
    check_eq("error in conf reset", 32'd0, 32'(load_error));
    host_write(HOST_ADDR_CONF, 8'h00);

    test_name = "trainer";
    send_header(1, 0, 8'h04, 8'h00, 1'b0);  // Trainer flag set
    wait_level(1'b1, 0, "load_error");
    send_junk(32);

    check_eq("pending writes", 32'd0, 32'(exp_addr_q.size()));
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule
